// ==== Makefile ====
# verilator build and run of the fft stage testbench
VERILATOR ?= verilator
TOP       ?= cc_fft_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
logic/cc_fft_pkg.sv
logic/fft_config_regs.sv
logic/frame_loader.sv
logic/fft_radix2_core.sv
logic/cc_fft_top.sv
verif/cc_fft_chk.sv
verif/cc_fft_tb.sv

// ==== logic/cc_fft_pkg.sv ====
/* cross-correlation fft shared definitions
   sample and complex word types, schedule field width, twiddle generator */
`default_nettype none

package cc_fft_pkg;

  localparam int sample_w = 16; // one real or imaginary part
  localparam int cplx_w   = 2 * sample_w; // imag over real
  localparam int shift_w  = 2; // per-stage shift 0..3

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic [cplx_w-1:0]          cplx_t;

  // twiddles are q2.14 so that 1.0 is exact
  localparam int  tw_one = 1 << (sample_w - 2);
  localparam real pi     = 3.14159265358979;

  // cos and sin of 2*pi*k/n, packed sin over cos
  // the core conjugates as needed for direction
  function automatic cplx_t twiddle(input int k, input int n);
    real     ang;
    real     c;
    real     s;
    sample_t c_q;
    sample_t s_q;
    ang = 2.0 * pi * real'(k) / real'(n);
    c   = $cos(ang) * real'(tw_one);
    s   = $sin(ang) * real'(tw_one);
    c_q = sample_t'($rtoi(c < 0.0 ? c - 0.5 : c + 0.5)); // round to nearest
    s_q = sample_t'($rtoi(s < 0.0 ? s - 0.5 : s + 0.5));
    return {s_q, c_q};
  endfunction

endpackage

`default_nettype wire

// ==== logic/cc_fft_top.sv ====
/* cross-correlation fft stage top, config regs, frame loader and radix-2 core */
`default_nettype none

module cc_fft_top import cc_fft_pkg::*; #(
  parameter int n_log2 = 4 // n = 16
) (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         cfg_valid,
  output logic                              cfg_ready,
  input  wire logic                         cfg_fwd,
  input  wire logic [shift_w*n_log2-1:0]    cfg_schedule,
  input  wire logic                         in_valid,
  output logic                              in_ready,
  input  wire sample_t                      in_data,
  input  wire logic                         in_last,
  output logic                              out_valid,
  input  wire logic                         out_ready,
  output cplx_t                             out_data,
  output logic      [n_log2-1:0]            out_index,
  output logic                              out_last,
  output logic                              event_frame_started,
  output logic                              event_tlast_unexpected,
  output logic                              event_tlast_missing,
  output logic                              event_fft_overflow
);

  logic                        core_busy;
  logic                        frame_loaded;
  logic                        wr_en;
  logic [n_log2-1:0]           wr_addr;
  cplx_t                       wr_data;
  logic                        act_fwd;
  logic [shift_w*n_log2-1:0]   act_schedule;

  fft_config_regs #(.n_log2(n_log2)) i_cfg (
    .clk, .arst_n, .cfg_valid, .cfg_fwd, .cfg_schedule, .core_busy, .frame_loaded,
    .cfg_ready, .act_fwd, .act_schedule
  );

  frame_loader #(.n_log2(n_log2)) i_loader (
    .clk, .arst_n, .in_valid, .in_data, .in_last, .core_busy,
    .in_ready, .wr_en, .wr_addr, .wr_data, .frame_loaded,
    .event_frame_started, .event_tlast_unexpected, .event_tlast_missing
  );

  fft_radix2_core #(.n_log2(n_log2)) i_core (
    .clk, .arst_n, .wr_en, .wr_addr, .wr_data, .frame_loaded,
    .act_fwd, .act_schedule, .out_ready,
    .core_busy, .out_valid, .out_data, .out_index, .out_last, .event_fft_overflow
  );

endmodule

`default_nettype wire

// ==== logic/fft_config_regs.sv ====
/* fft configuration registers
   pending word from the cfg handshake, promoted to active at frame load */
`default_nettype none

module fft_config_regs import cc_fft_pkg::*; #(
  parameter int n_log2 = 4
) (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         cfg_valid,
  input  wire logic                         cfg_fwd,
  input  wire logic [shift_w*n_log2-1:0]    cfg_schedule,
  input  wire logic                         core_busy,
  input  wire logic                         frame_loaded,
  output logic                              cfg_ready,
  output logic                              act_fwd,
  output logic      [shift_w*n_log2-1:0]    act_schedule
);

  localparam int sched_w = shift_w * n_log2;

  // one bit of shift per stage by default
  localparam logic [sched_w-1:0] sched_dflt = {n_log2{shift_w'(1)}};

  logic               pend_fwd;
  logic [sched_w-1:0] pend_schedule;
  logic               cfg_acc;

  assign cfg_ready = ~core_busy; // only while core idle
  assign cfg_acc   = cfg_valid & cfg_ready;

  // pending copy, written by handshake
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_fwd      <= 1'b1; // forward
      pend_schedule <= sched_dflt;
    end else if (cfg_acc) begin
      pend_fwd      <= cfg_fwd;
      pend_schedule <= cfg_schedule;
    end
  end

  // active copy, frozen for the frame in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      act_fwd      <= 1'b1;
      act_schedule <= sched_dflt;
    end else if (frame_loaded) begin
      act_fwd      <= pend_fwd;      // old pending wins over a same-cycle write
      act_schedule <= pend_schedule;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fft_radix2_core.sv ====
/* in-place radix-2 dit fft over a flop frame memory, per-stage shift and
   saturation, natural-order output through bit-reversed reads */
`default_nettype none

module fft_radix2_core import cc_fft_pkg::*; #(
  parameter int n_log2 = 4
) (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         wr_en,
  input  wire logic [n_log2-1:0]            wr_addr,
  input  wire cplx_t                        wr_data,
  input  wire logic                         frame_loaded,
  input  wire logic                         act_fwd,
  input  wire logic [shift_w*n_log2-1:0]    act_schedule,
  input  wire logic                         out_ready,
  output logic                              core_busy,
  output logic                              out_valid,
  output cplx_t                             out_data,
  output logic      [n_log2-1:0]            out_index,
  output logic                              out_last,
  output logic                              event_fft_overflow
);

  localparam int n       = 1 << n_log2;
  localparam int stage_w = $clog2(n_log2);
  localparam int span_w  = stage_w + 1;
  localparam int prod_w  = 2 * sample_w + 1;
  localparam int acc_w   = sample_w + 4; // headroom for a +- w*b

  localparam logic signed [prod_w-1:0] tw_rnd  = prod_w'(1 << (sample_w - 3));
  localparam logic signed [acc_w-1:0]  sat_max = acc_w'((1 << (sample_w - 1)) - 1);
  localparam logic signed [acc_w-1:0]  sat_min = -acc_w'(1 << (sample_w - 1));

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_run  = 2'd1;
  localparam logic [1:0] st_out  = 2'd2;

  // reverse the low w bits of v
  function automatic logic [n_log2-1:0] rev_bits(input logic [n_log2-1:0] v, input int w);
    logic [n_log2-1:0] r;
    r = '0;
    for (int i = 0; i < w; i++) begin
      r[i] = v[w-1-i];
    end
    return r;
  endfunction

  // arithmetic shift then clamp, msb flags saturation
  function automatic logic [sample_w:0] scale_sat(input logic signed [acc_w-1:0] v,
                                                  input logic [shift_w-1:0] sh);
    logic signed [acc_w-1:0] t;
    t = v >>> sh;
    if (t > sat_max) return {1'b1, sat_max[sample_w-1:0]};
    else if (t < sat_min) return {1'b1, sat_min[sample_w-1:0]};
    else return {1'b0, t[sample_w-1:0]};
  endfunction

  cplx_t mem [n];       // frame memory, in place
  cplx_t tw_rom [n/2];  // w^e for e in 0..n/2-1

  for (genvar gi = 0; gi < n/2; gi++) begin : g_tw
    localparam cplx_t tw_val = twiddle(gi, n);
    assign tw_rom[gi] = tw_val;
  end

  logic [1:0]          state;
  logic [stage_w-1:0]  stage;
  logic [n_log2-1:0]   cnt;     // cycle within stage, n/2 issues plus 2 drain
  logic [n_log2-1:0]   out_idx;

  // butterfly addressing
  logic [span_w-1:0]   span_bit; // pair distance is 2^span_bit
  logic [n_log2-1:0]   lo_mask;
  logic [n_log2-1:0]   bf_ext;
  logic [n_log2-1:0]   addr_p;
  logic [n_log2-1:0]   addr_q;
  logic [n_log2-1:0]   tw_rev;
  logic                issue;

  assign issue = (state == st_run) & ~cnt[n_log2-1]; // cnt < n/2

  always_comb begin
    span_bit = span_w'(n_log2 - 1) - span_w'(stage);
    lo_mask  = (n_log2'(1) << span_bit) - 1'b1;
    bf_ext   = {1'b0, cnt[n_log2-2:0]};
    addr_p   = ((bf_ext & ~lo_mask) << 1) | (bf_ext & lo_mask); // zero at span_bit
    addr_q   = addr_p | (lo_mask + 1'b1);
    tw_rev   = rev_bits(bf_ext >> span_bit, n_log2 - 1); // exponent, multiple of 2^span_bit
  end

  // read stage registers
  cplx_t             rd_a;
  cplx_t             rd_b;
  cplx_t             rd_w;
  logic [n_log2-1:0] rd_p;
  logic [n_log2-1:0] rd_q;
  logic              rd_v;

  always_ff @(posedge clk) begin
    rd_a <= mem[addr_p];
    rd_b <= mem[addr_q];
    rd_w <= tw_rom[tw_rev[n_log2-2:0]];
    rd_p <= addr_p;
    rd_q <= addr_q;
  end

  // butterfly, a +- w*b
  sample_t                  a_re, a_im, b_re, b_im, w_re, w_im;
  logic signed [prod_w-1:0] m_rr, m_ii, m_ri, m_ir, t_re, t_im;
  logic signed [acc_w-1:0]  wb_re, wb_im;
  logic [shift_w-1:0]       sh;
  logic [sample_w:0]        r0_re, r0_im, r1_re, r1_im;
  logic                     bf_ovf;
  logic                     ovf_q;

  assign a_re = rd_a[sample_w-1:0];
  assign a_im = rd_a[cplx_w-1:sample_w];
  assign b_re = rd_b[sample_w-1:0];
  assign b_im = rd_b[cplx_w-1:sample_w];
  assign w_re = rd_w[sample_w-1:0];
  assign w_im = act_fwd ? -sample_t'(rd_w[cplx_w-1:sample_w])  // e^-j for forward
                        : sample_t'(rd_w[cplx_w-1:sample_w]);  // conjugate for inverse

  assign m_rr  = b_re * w_re;
  assign m_ii  = b_im * w_im;
  assign m_ri  = b_re * w_im;
  assign m_ir  = b_im * w_re;
  assign t_re  = (m_rr - m_ii + tw_rnd) >>> (sample_w - 2); // back from q2.14
  assign t_im  = (m_ri + m_ir + tw_rnd) >>> (sample_w - 2);
  assign wb_re = $signed(t_re[acc_w-1:0]);
  assign wb_im = $signed(t_im[acc_w-1:0]);

  assign sh    = act_schedule[stage*shift_w +: shift_w]; // stage 0 in low field
  assign r0_re = scale_sat(acc_w'(a_re) + wb_re, sh);
  assign r0_im = scale_sat(acc_w'(a_im) + wb_im, sh);
  assign r1_re = scale_sat(acc_w'(a_re) - wb_re, sh);
  assign r1_im = scale_sat(acc_w'(a_im) - wb_im, sh);

  assign bf_ovf = rd_v & (r0_re[sample_w] | r0_im[sample_w] | r1_re[sample_w] | r1_im[sample_w]);
  assign event_fft_overflow = bf_ovf & ~ovf_q; // one pulse per run of saturating butterflies

  // loader writes while idle, butterflies while running
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    if (rd_v) begin
      mem[rd_p] <= {r0_im[sample_w-1:0], r0_re[sample_w-1:0]};
      mem[rd_q] <= {r1_im[sample_w-1:0], r1_re[sample_w-1:0]};
    end
  end

  // output read, bin k lives at rev(k)
  logic [n_log2-1:0] out_rd;
  assign out_rd = rev_bits(out_idx + 1'b1, n_log2);

  always_ff @(posedge clk) begin
    if (state == st_run) out_data <= mem[0]; // bin 0 at address 0
    else if (out_valid && out_ready) out_data <= mem[out_rd];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_idle;
      stage     <= '0;
      cnt       <= '0;
      out_idx   <= '0;
      out_valid <= 1'b0;
      rd_v      <= 1'b0;
      ovf_q     <= 1'b0;
    end else begin
      rd_v  <= issue;
      ovf_q <= bf_ovf;
      case (state)
        st_idle: begin
          if (frame_loaded) begin
            state <= st_run;
            stage <= '0;
            cnt   <= '0;
          end
        end
        st_run: begin
          cnt <= cnt + 1'b1;
          if (cnt == n_log2'(n/2 + 1)) begin // last write landed a cycle ago
            cnt <= '0;
            if (stage == stage_w'(n_log2 - 1)) begin
              state     <= st_out;
              out_valid <= 1'b1;
            end else begin
              stage <= stage + 1'b1;
            end
          end
        end
        default: begin
          if (out_valid && out_ready) begin
            out_idx <= out_idx + 1'b1; // wraps to 0 after bin n-1
            if (&out_idx) begin
              out_valid <= 1'b0;
              state     <= st_idle;
            end
          end
        end
      endcase
    end
  end

  assign core_busy = (state != st_idle) | frame_loaded;
  assign out_index = out_idx;
  assign out_last  = out_valid & (&out_idx);

endmodule

`default_nettype wire

// ==== logic/frame_loader.sv ====
/* frame loader, zero fills the lower half of the fft frame and
   writes n/2 real samples into the upper half, with tlast checks */
`default_nettype none

module frame_loader import cc_fft_pkg::*; #(
  parameter int n_log2 = 4
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                in_valid,
  input  wire sample_t             in_data,
  input  wire logic                in_last,
  input  wire logic                core_busy,
  output logic                     in_ready,
  output logic                     wr_en,
  output logic      [n_log2-1:0]   wr_addr,
  output cplx_t                    wr_data,
  output logic                     frame_loaded,
  output logic                     event_frame_started,
  output logic                     event_tlast_unexpected,
  output logic                     event_tlast_missing
);

  localparam logic [1:0] st_zero = 2'd0; // clearing lower half
  localparam logic [1:0] st_fill = 2'd1; // taking samples
  localparam logic [1:0] st_hold = 2'd2; // core owns memory

  logic [1:0]        state;
  logic [n_log2-2:0] cnt;      // half-frame position
  logic              accept;
  logic              last_smp; // n/2-th sample

  assign in_ready = (state == st_fill); // core stays idle until this frame is loaded
  assign accept   = in_valid & in_ready;
  assign last_smp = &cnt;

  // top address bit picks the half
  assign wr_en   = (state == st_zero) | accept;
  assign wr_addr = {state != st_zero, cnt};
  assign wr_data = (state == st_zero) ? '0 : {{sample_w{1'b0}}, in_data}; // imag zero

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state                  <= st_zero;
      cnt                    <= '0;
      frame_loaded           <= 1'b0;
      event_frame_started    <= 1'b0;
      event_tlast_unexpected <= 1'b0;
      event_tlast_missing    <= 1'b0;
    end else begin
      frame_loaded           <= accept & last_smp;
      event_frame_started    <= accept & (cnt == '0);
      event_tlast_unexpected <= accept & in_last & ~last_smp; // frame still runs to n/2
      event_tlast_missing    <= accept & ~in_last & last_smp;
      case (state)
        st_zero: begin
          cnt <= cnt + 1'b1; // wraps to 0 for fill
          if (last_smp) state <= st_fill;
        end
        st_fill: begin
          if (accept) begin
            cnt <= cnt + 1'b1;
            if (last_smp) state <= st_hold;
          end
        end
        default: begin
          // busy covers the frame_loaded cycle too
          if (!core_busy) state <= st_zero;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verif/cc_fft_chk.sv ====
/* bound assertions for the fft stage
   output hold under back-pressure, loader lockout, single-cycle events */
`default_nettype none

module cc_fft_chk import cc_fft_pkg::*; #(
  parameter int n_log2 = 4
) (
  input wire logic              clk,
  input wire logic              arst_n,
  input wire logic              core_busy,
  input wire logic              in_ready,
  input wire logic              out_valid,
  input wire logic              out_ready,
  input wire cplx_t             out_data,
  input wire logic [n_log2-1:0] out_index,
  input wire logic              event_frame_started,
  input wire logic              event_tlast_unexpected,
  input wire logic              event_tlast_missing,
  input wire logic              event_fft_overflow
);

  int fail_cnt = 0; // summed into the testbench error count

  logic [3:0] ev;
  assign ev = {event_frame_started, event_tlast_unexpected, event_tlast_missing,
               event_fft_overflow};

  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> $stable(out_data) && $stable(out_index))
    else begin
      fail_cnt++;
      $error("output bin changed while out_ready was low");
    end

  // loader must not touch memory the core owns
  a_in_lock: assert property (@(posedge clk) disable iff (!arst_n) core_busy |-> !in_ready)
    else begin
      fail_cnt++;
      $error("in_ready high while the core is busy");
    end

  a_ev_pulse: assert property (@(posedge clk) disable iff (!arst_n) (ev & $past(ev)) == '0)
    else begin
      fail_cnt++;
      $error("event held longer than one cycle");
    end

endmodule

bind cc_fft_top cc_fft_chk #(.n_log2(n_log2)) i_chk (
  .clk, .arst_n, .core_busy, .in_ready, .out_valid, .out_ready, .out_data, .out_index,
  .event_frame_started, .event_tlast_unexpected, .event_tlast_missing, .event_fft_overflow
);

`default_nettype wire

// ==== verif/cc_fft_tb.sv ====
/* testbench for the cross-correlation fft stage
   table of frames, checks bins, indices, out_last and event counts */
`default_nettype none

module cc_fft_tb import cc_fft_pkg::*; ();

  localparam int n_log2      = 4;
  localparam int n           = 1 << n_log2;
  localparam int half        = n / 2;
  localparam int sched_w     = shift_w * n_log2;
  localparam int n_rows      = 7;
  localparam int max_wait    = 2000; // cycles per wait loop
  localparam int pat_impulse = 0;
  localparam int pat_const   = 1;
  localparam int s_max       = (1 << (sample_w - 1)) - 1;

  logic               clk = 1'b0;
  logic               arst_n;
  logic               cfg_valid;
  logic               cfg_ready;
  logic               cfg_fwd;
  logic [sched_w-1:0] cfg_schedule;
  logic               in_valid;
  logic               in_ready;
  sample_t            in_data;
  logic               in_last;
  logic               out_valid;
  logic               out_ready;
  cplx_t              out_data;
  logic [n_log2-1:0]  out_index;
  logic               out_last;
  logic               event_frame_started;
  logic               event_tlast_unexpected;
  logic               event_tlast_missing;
  logic               event_fft_overflow;

  // stimulus table, one row per test
  string              t_name  [n_rows];
  logic               t_fwd   [n_rows];
  logic [sched_w-1:0] t_sched [n_rows];
  int                 t_pat   [n_rows];
  int                 t_amp   [n_rows]; // 0 draws a random amplitude
  int                 t_last  [n_rows]; // sample with in_last, -1 none
  logic               t_bp    [n_rows]; // random out_ready
  logic               t_hold  [n_rows]; // config offered during output
  int                 t_unexp [n_rows];
  int                 t_miss  [n_rows];
  int                 t_ovf   [n_rows]; // minimum count

  int seed;
  int n_start, n_unexp, n_miss, n_ovf;
  int n_err_val, n_err_evt, n_timeout;
  bit hung;

  cc_fft_top #(.n_log2(n_log2)) i_dut (.*);

  always #50 clk = ~clk;

  always @(negedge clk) begin // mid-cycle, events are settled
    if (event_frame_started) n_start++;
    if (event_tlast_unexpected) n_unexp++;
    if (event_tlast_missing) n_miss++;
    if (event_fft_overflow) n_ovf++;
  end

  task automatic add_row(input int i, input string name, input logic fwd,
                         input logic [sched_w-1:0] sched, input int pat, input int amp,
                         input int last, input logic bp, input logic hold,
                         input int unexp, input int miss, input int ovf);
    t_name[i]  = name;
    t_fwd[i]   = fwd;
    t_sched[i] = sched;
    t_pat[i]   = pat;
    t_amp[i]   = amp;
    t_last[i]  = last;
    t_bp[i]    = bp;
    t_hold[i]  = hold;
    t_unexp[i] = unexp;
    t_miss[i]  = miss;
    t_ovf[i]   = ovf;
  endtask

  // total right shift over all stages
  function automatic int sched_sum(input logic [sched_w-1:0] s);
    int t;
    t = 0;
    for (int i = 0; i < n_log2; i++) begin
      t += int'(s[i*shift_w +: shift_w]);
    end
    return t;
  endfunction

  // impulse at frame index n/2 gives A*(-1)^k, constant gives (n/2)*A in bin 0
  function automatic cplx_t expect_bin(input int pat, input int amp, input int tot,
                                       input int k);
    int re;
    if (pat == pat_impulse) re = ((k % 2 != 0) ? -amp : amp) >>> tot;
    else re = (k == 0) ? (half * amp) >>> tot : 0;
    if (re > s_max) re = s_max; // saturation
    if (re < -s_max - 1) re = -s_max - 1;
    return {{sample_w{1'b0}}, sample_t'(re)};
  endfunction

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("timeout in test %s, %s", name, what);
    n_timeout++;
    hung = 1'b1;
  endtask

  task automatic check_cplx(input string name, input int k, input cplx_t exp_v, input cplx_t act);
    if (act !== exp_v) begin
      $display("[ERROR] %s bin %0d expected %h actual %h", name, k, exp_v, act);
      n_err_val++;
    end
  endtask

  task automatic check_index(input string name, input logic [n_log2-1:0] exp_v,
                             input logic [n_log2-1:0] act);
    if (act !== exp_v) begin
      $display("[ERROR] %s out_index expected %0d actual %0d", name, exp_v, act);
      n_err_val++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp_v,
                            input logic act);
    if (act !== exp_v) begin
      $display("[ERROR] %s %s expected %b actual %b", name, what, exp_v, act);
      n_err_val++;
    end
  endtask

  task automatic check_event(input string name, input string what, input int exp_v,
                             input int act, input bit at_least);
    if (at_least ? act < exp_v : act != exp_v) begin
      $display("[ERROR] %s %s count expected %s%0d actual %0d", name, what,
               at_least ? "at least " : "", exp_v, act);
      n_err_evt++;
    end
  endtask

  task automatic send_cfg(input string name, input logic fwd, input logic [sched_w-1:0] sched);
    int t;
    t            = 0;
    cfg_valid    = 1'b1;
    cfg_fwd      = fwd;
    cfg_schedule = sched;
    while (!cfg_ready && !hung) begin
      step();
      t++;
      if (t > max_wait) report_timeout(name, "cfg_ready stayed low");
    end
    step(); // accepted on this edge
    cfg_valid = 1'b0;
  endtask

  task automatic send_frame(input int r, input int amp);
    int t;
    for (int i = 0; i < half; i++) begin
      in_valid = 1'b1;
      in_data  = (t_pat[r] == pat_const || i == 0) ? sample_t'(amp) : '0;
      in_last  = (i == t_last[r]);
      t = 0;
      while (!in_ready && !hung) begin // zero fill or busy core
        step();
        t++;
        if (t > max_wait) report_timeout(t_name[r], "in_ready stayed low");
      end
      step();
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic collect_bins(input int r, input int amp, input int tot);
    int t;
    int k;
    t = 0;
    k = 0;
    while (k < n && !hung) begin
      out_ready = t_bp[r] ? 1'($random(seed)) : 1'b1;
      if (out_valid && out_ready) begin // handshake on the coming edge
        check_index(t_name[r], n_log2'(k), out_index);
        check_flag(t_name[r], "out_last", k == n - 1, out_last);
        check_flag(t_name[r], "cfg_ready", 1'b0, cfg_ready); // core busy until last bin
        if (t_pat[r] == pat_impulse || k % 2 == 0) // odd constant bins carry twiddle rounding
          check_cplx(t_name[r], k, expect_bin(t_pat[r], amp, tot, k), out_data);
        k++;
        t = 0;
      end
      step();
      t++;
      if (t > max_wait) report_timeout(t_name[r], "no output bin arrived");
    end
    out_ready = 1'b0;
  endtask

  initial begin
    int amp;
    int tot;
    seed         = 48;
    arst_n       = 1'b0;
    cfg_valid    = 1'b0;
    cfg_fwd      = 1'b1;
    cfg_schedule = '0;
    in_valid     = 1'b0;
    in_data      = '0;
    in_last      = 1'b0;
    out_ready    = 1'b0;
    //      name             fwd   sched  pattern      amp   last  bp    hold unx mis ovf
    add_row(0, "impulse_fwd",   1'b1, 8'h55, pat_impulse, 1600,   7, 1'b0, 1'b0, 0, 0, 0);
    add_row(1, "const_fwd",     1'b1, 8'h55, pat_const,    800,   7, 1'b0, 1'b0, 0, 0, 0);
    add_row(2, "impulse_inv",   1'b0, 8'h65, pat_impulse, 3200,   7, 1'b0, 1'b1, 0, 0, 0);
    add_row(3, "tlast_early",   1'b1, 8'h55, pat_impulse, -480,   3, 1'b0, 1'b0, 1, 1, 0);
    add_row(4, "tlast_missing", 1'b1, 8'h55, pat_impulse,  960,  -1, 1'b0, 1'b0, 0, 1, 0);
    add_row(5, "overflow",      1'b1, 8'h00, pat_const,  30000,   7, 1'b0, 1'b0, 0, 0, 1);
    add_row(6, "random_ready",  1'b1, 8'h55, pat_impulse,    0,   7, 1'b1, 1'b0, 0, 0, 0);
    repeat (3) @(posedge clk);
    #10;
    arst_n = 1'b1;
    for (int r = 0; r < n_rows && !hung; r++) begin
      tot = sched_sum(t_sched[r]);
      amp = t_amp[r];
      if (amp == 0) amp = (($random(seed) % 4096) >>> tot) <<< tot; // exact under the shifts
      n_start = 0;
      n_unexp = 0;
      n_miss  = 0;
      n_ovf   = 0;
      send_cfg(t_name[r], t_fwd[r], t_sched[r]);
      send_frame(r, amp);
      if (t_hold[r]) begin // would change the result if it reached this frame
        cfg_valid    = 1'b1;
        cfg_fwd      = 1'b1;
        cfg_schedule = '0;
      end
      collect_bins(r, amp, tot);
      if (t_hold[r]) send_cfg(t_name[r], 1'b1, '0); // taken once the core goes idle
      check_event(t_name[r], "frame_started", 1, n_start, 1'b0);
      check_event(t_name[r], "tlast_unexpected", t_unexp[r], n_unexp, 1'b0);
      check_event(t_name[r], "tlast_missing", t_miss[r], n_miss, 1'b0);
      check_event(t_name[r], "fft_overflow", t_ovf[r], n_ovf, t_ovf[r] > 0);
    end
    $display("errors: values %0d, events %0d, timeouts %0d, assertions %0d",
             n_err_val, n_err_evt, n_timeout, i_dut.i_chk.fail_cnt);
    if (n_err_val + n_err_evt + n_timeout + i_dut.i_chk.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
